//--- Makefile
# Verilator flow for the binary16 add/sub pipeline
VERILATOR ?= verilator
TOP ?= tbFpAddSub
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim.f
source/fpAddPkg.sv
source/fpUnpackStage.sv
source/fpAlignStage.sv
source/fpMantAddStage.sv
source/fpNormalizeStage.sv
source/fpRoundStage.sv
source/fpAddSub.sv
sim/fpAddSub_sva.sv
sim/tbFpAddSub.sv

//--- sim/fpAddSub_sva.sv
`timescale 1ns/10ps
`default_nettype none

module fpAddSub_sva (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input logic outVld,
	input logic [fpAddPkg::dataW-1:0] result,
	input fpAddPkg::fpFlagsT flags
);

	// Every strobe comes out exactly pipeDepth edges later
	latencyChk: assert property (@(posedge aclk) disable iff (rst)
		outVld == $past(inVld, fpAddPkg::pipeDepth))
		else $error("outVld does not follow inVld by %0d cycles", fpAddPkg::pipeDepth);

	// Quiet while in reset and while the pipe refills
	for (genvar i = 1; i <= fpAddPkg::pipeDepth; i++) begin : rstQuiet
		quietChk: assert property (@(posedge aclk) $past(rst, i) |-> !outVld)
			else $error("outVld high %0d cycles after reset was sampled", i);
	end

	invalidChk: assert property (@(posedge aclk) disable iff (rst)
		(outVld && flags.invalid) |-> (result == fpAddPkg::qNan))
		else $error("Invalid flag raised without the quiet NaN result");

	// No X leaking out with a valid strobe
	knownChk: assert property (@(posedge aclk) disable iff (rst)
		outVld |-> !$isunknown({result, flags}))
		else $error("Unknown result or flags on a valid output");

endmodule

bind fpAddSub fpAddSub_sva u_sva (.*);

`default_nettype wire

//--- sim/tbFpAddSub.sv
`timescale 1ns/10ps
`default_nettype none

module tbFpAddSub;

	localparam int bias = 15;                      // binary16 exponent bias
	localparam int opBudget = 700;                 // Upper bound on ops over all tests
	localparam int cycleLimit = 4 * opBudget + 200; // Gaps, latency and reset on top

	logic aclk;
	logic rst;
	logic inVld;
	logic [fpAddPkg::dataW-1:0] opA, opB;
	fpAddPkg::addSubOpE op;
	logic outVld;
	logic [fpAddPkg::dataW-1:0] result;
	fpAddPkg::fpFlagsT flags;

	logic [31:0] lfsr = 32'ha84ed7e3;
	logic [19:0] expQ[$];                          // {result, flags} in send order
	int errors = 0;
	int cycles = 0;

	fpAddSub u_dut (.aclk(aclk), .rst(rst), .inVld(inVld), .opA(opA), .opB(opB), .op(op),
		.outVld(outVld), .result(result), .flags(flags));

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// Fibonacci taps 32, 22, 2, 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};       // One step per bit taken
		end
		return val;
	endfunction

	// Integer to binary16 with nearest even and saturation to infinity
	function automatic logic [19:0] intToHalf(input int v);
		logic sign;
		int mag, msb, sh, kept, rem, mid;
		fpAddPkg::fpFlagsT fl;
		fl = '0;
		sign = (v < 0);
		mag = sign ? -v : v;
		if (mag == 0)
			return 20'h0;                // Exact +0
		msb = 0;
		for (int i = 0; i < 31; i++) begin
			if ((mag >> i) != 0)
				msb = i;
		end
		sh = (msb > fpAddPkg::manW) ? msb - fpAddPkg::manW : 0;
		kept = mag >> sh;                // Top 11 bits
		rem = mag - (kept << sh);
		if (msb < fpAddPkg::manW)
			kept = kept << (fpAddPkg::manW - msb); // Hidden one up to bit 10
		if (sh > 0) begin
			mid = 1 << (sh - 1);
			if (rem > mid || (rem == mid && kept % 2 == 1))
				kept++;
			if (kept == (1 << fpAddPkg::sigW)) begin
				kept = kept >> 1;        // Round carried into next binade
				msb++;
			end
			fl.inexact = (rem != 0);
		end
		if (msb + bias >= fpAddPkg::expMax) begin
			fl.overflow = 1'b1;
			fl.inexact = 1'b1;
			return {sign, 5'(fpAddPkg::expMax), 10'h0, fl};
		end
		return {sign, 5'(msb + bias), 10'(kept), fl}; // Hidden bit drops off
	endfunction

	function automatic logic [15:0] toHalf(input int v);
		logic [19:0] enc;
		enc = intToHalf(v);
		return enc[19:4];
	endfunction

	task automatic sendOp(input logic [15:0] a, input logic [15:0] b,
		input fpAddPkg::addSubOpE o, input logic [19:0] want);
		@(posedge aclk);
		#1;
		inVld = 1'b1;
		opA = a;
		opB = b;
		op = o;
		expQ.push_back(want);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge aclk);
			#1;
			inVld = 1'b0;
		end
	endtask

	// Outputs settle after posedge and are read half a cycle later
	always @(negedge aclk) begin
		logic [19:0] want;
		if (outVld) begin
			if (expQ.size() == 0) begin
				$display("Output valid at %0t with no operation pending", $time);
				errors++;
			end else begin
				want = expQ.pop_front();
				assert (result == want[19:4]) else begin
					$display("[FAIL] %0t result %h, expected %h", $time, result, want[19:4]);
					errors++;
				end
				assert (flags == want[3:0]) else begin
					$display("[FAIL] %0t flags %b, expected %b", $time, flags, want[3:0]);
					errors++;
				end
			end
		end
	end

	always @(posedge aclk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout, run still going after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		int a, b;
		rst = 1'b1;
		inVld = 1'b0;
		opA = '0;
		opB = '0;
		op = fpAddPkg::opAdd;
		repeat (5) @(posedge aclk);
		#1;
		rst = 1'b0;
		repeat (150) begin                         // Exact sums back to back
			a = randBits(10);
			b = randBits(10);
			sendOp(toHalf(a), toHalf(b), fpAddPkg::opAdd, intToHalf(a + b));
		end
		repeat (100) begin                         // Differences of either sign
			a = randBits(10);
			b = randBits(10);
			sendOp(toHalf(a), toHalf(b), fpAddPkg::opSub, intToHalf(a - b));
			sendOp(toHalf(a), toHalf(-b), fpAddPkg::opAdd, intToHalf(a - b));
		end
		repeat (4) begin
			a = randBits(10);
			sendOp(toHalf(a), toHalf(a), fpAddPkg::opSub, 20'h0); // Cancels to +0
		end
		repeat (150) begin                         // Step of 2 above 2048
			a = 2048 + 2 * int'(randBits(10));
			b = 1 + int'(randBits(2)) % 3;
			sendOp(toHalf(a), toHalf(b), fpAddPkg::opAdd, intToHalf(a + b));
		end
		sendOp(toHalf(65504), toHalf(65504), fpAddPkg::opAdd, intToHalf(131008));
		sendOp(16'h0401, 16'h0400, fpAddPkg::opSub, {16'h0000, 4'b0101}); // Flush to zero
		repeat (3) begin
			a = randBits(10);
			sendOp({1'b0, 5'h1F, 10'(randBits(10)) | 10'd1}, toHalf(a), fpAddPkg::opAdd,
				{fpAddPkg::qNan, 4'b0010});
			sendOp(toHalf(a), {1'b1, 5'h1F, 10'h200}, fpAddPkg::opSub,
				{fpAddPkg::qNan, 4'b0010});
			sendOp(16'h7C00, toHalf(a), fpAddPkg::opAdd, {16'h7C00, 4'b1000}); // +inf stays
		end
		sendOp(16'h7C00, 16'h7C00, fpAddPkg::opSub, {fpAddPkg::qNan, 4'b0010});
		sendOp(16'h7C00, 16'hFC00, fpAddPkg::opAdd, {fpAddPkg::qNan, 4'b0010});
		repeat (20) begin                          // Bursts with random gaps
			repeat (int'(randBits(2)) + 1) begin
				a = randBits(10);
				b = randBits(10);
				sendOp(toHalf(a), toHalf(b), fpAddPkg::opAdd, intToHalf(a + b));
			end
			idle(int'(randBits(2)));
		end
		idle(fpAddPkg::pipeDepth + 3);            // Drain the pipe
		if (expQ.size() != 0) begin
			$display("%0d results never came out of the pipeline", expQ.size());
			errors++;
		end
		$display("Checks done with %0d errors", errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/fpAddPkg.sv
`default_nettype none

package fpAddPkg;

	// binary16 field widths
	localparam int expW = 5;
	localparam int manW = 10;
	localparam int dataW = 16;
	localparam int sigW = 11;                   // Fraction plus hidden one
	localparam int grsW = 3;                    // Guard, round, sticky
	localparam int extW = sigW + grsW;          // Significand with grs tail
	localparam int expMax = 31;                 // All-ones exponent
	localparam logic [dataW-1:0] qNan = 16'h7E00;
	localparam int pipeDepth = 5;               // Input strobe to outVld

	typedef enum logic {
		opAdd = 1'b0,
		opSub = 1'b1
	} addSubOpE;

	// Ordered as in the flag word, MSB first
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic invalid;
		logic inexact;
	} fpFlagsT;

	// Operand class carried down the pipe, overrides the datapath at the end
	typedef enum logic [1:0] {
		spNone,
		spNan,
		spInf,
		spInfMinusInf
	} specialE;

	typedef struct packed {
		logic [expW-1:0] exp;                   // Exponent of larger operand
		logic [sigW-1:0] sigL;                  // Larger significand
		logic [sigW-1:0] sigS;                  // Smaller significand
		logic [4:0] shift;                      // Exponent difference
		logic sign;
		logic effSub;
		specialE special;
	} unpackT;

	typedef struct packed {
		logic [expW-1:0] exp;
		logic [sigW-1:0] sigL;
		logic [extW-1:0] sigS;                  // Aligned, grs in low bits
		logic sign;
		logic effSub;
		specialE special;
	} alignT;

	typedef struct packed {
		logic [expW-1:0] exp;
		logic [extW:0] sum;                     // MSB catches the add carry
		logic sign;
		specialE special;
	} sumT;

	typedef struct packed {
		logic [expW:0] exp;                     // Extra bit for overflow
		logic [extW-1:0] sig;                   // Hidden one at MSB
		logic sign;
		logic zero;
		logic uflow;
		specialE special;
	} normT;

endpackage

`default_nettype wire

//--- source/fpAddSub.sv
`timescale 1ns/10ps
`default_nettype none

module fpAddSub (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input logic [fpAddPkg::dataW-1:0] opA,
	input logic [fpAddPkg::dataW-1:0] opB,
	input fpAddPkg::addSubOpE op,
	output logic outVld,
	output logic [fpAddPkg::dataW-1:0] result,
	output fpAddPkg::fpFlagsT flags
);

	// Valid strobe rides next to each stage payload
	logic vld1, vld2, vld3, vld4;
	fpAddPkg::unpackT st1;
	fpAddPkg::alignT st2;
	fpAddPkg::sumT st3;
	fpAddPkg::normT st4;

	fpUnpackStage u_unpack (.aclk(aclk), .rst(rst), .inVld(inVld), .opA(opA), .opB(opB),
		.op(op), .vld(vld1), .stage(st1));

	fpAlignStage u_align (.aclk(aclk), .rst(rst), .inVld(vld1), .inStage(st1),
		.vld(vld2), .stage(st2));

	fpMantAddStage u_mantAdd (.aclk(aclk), .rst(rst), .inVld(vld2), .inStage(st2),
		.vld(vld3), .stage(st3));

	fpNormalizeStage u_normalize (.aclk(aclk), .rst(rst), .inVld(vld3), .inStage(st3),
		.vld(vld4), .stage(st4));

	fpRoundStage u_round (.aclk(aclk), .rst(rst), .inVld(vld4), .inStage(st4),
		.outVld(outVld), .result(result), .flags(flags));

endmodule

`default_nettype wire

//--- source/fpAlignStage.sv
`timescale 1ns/10ps
`default_nettype none

module fpAlignStage (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input fpAddPkg::unpackT inStage,
	output logic vld,
	output fpAddPkg::alignT stage
);

	logic [2*fpAddPkg::extW-1:0] lvl1Wide;     // Kept half above the lost bits
	logic [fpAddPkg::extW-1:0] lvl1;
	logic [fpAddPkg::extW+fpAddPkg::grsW-1:0] lvl2Wide;
	logic [fpAddPkg::extW-1:0] lvl2;
	logic sticky1, sticky2;
	fpAddPkg::alignT stageNext;

	// Coarse level in steps of 4 up to 28
	assign lvl1Wide = {inStage.sigS, {fpAddPkg::grsW{1'b0}}, {fpAddPkg::extW{1'b0}}}
		>> {inStage.shift[4:2], 2'b00};
	assign lvl1 = lvl1Wide[2*fpAddPkg::extW-1:fpAddPkg::extW];
	// A shift of 28 pushes every bit out of the window
	assign sticky1 = (|lvl1Wide[fpAddPkg::extW-1:0])
		| ((&inStage.shift[4:2]) & (|inStage.sigS));

	// Fine level of 0 to 3
	assign lvl2Wide = {lvl1, {fpAddPkg::grsW{1'b0}}} >> inStage.shift[1:0];
	assign lvl2 = lvl2Wide[fpAddPkg::extW+fpAddPkg::grsW-1:fpAddPkg::grsW];
	assign sticky2 = |lvl2Wide[fpAddPkg::grsW-1:0];

	always_comb begin
		stageNext.exp = inStage.exp;
		stageNext.sigL = inStage.sigL;
		// Everything past the round bit folds into sticky
		stageNext.sigS = {lvl2[fpAddPkg::extW-1:1], lvl2[0] | sticky1 | sticky2};
		stageNext.sign = inStage.sign;
		stageNext.effSub = inStage.effSub;
		stageNext.special = inStage.special;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			vld <= 1'b0;
		else
			vld <= inVld;
	end

	always_ff @(posedge aclk) begin
		stage <= stageNext;
	end

endmodule

`default_nettype wire

//--- source/fpMantAddStage.sv
`timescale 1ns/10ps
`default_nettype none

module fpMantAddStage (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input fpAddPkg::alignT inStage,
	output logic vld,
	output fpAddPkg::sumT stage
);

	logic [fpAddPkg::extW:0] opBig;            // Larger, with empty grs tail
	logic [fpAddPkg::extW:0] opSmall;
	logic [fpAddPkg::extW:0] sumAdd;
	logic [fpAddPkg::extW:0] sumSub;
	fpAddPkg::sumT stageNext;

	assign opBig = {1'b0, inStage.sigL, {fpAddPkg::grsW{1'b0}}};
	assign opSmall = {1'b0, inStage.sigS};

	assign sumAdd = opBig + opSmall;            // Carry lands in MSB
	// Operands are ordered by magnitude, so this stays non-negative
	assign sumSub = opBig - opSmall;

	always_comb begin
		stageNext.exp = inStage.exp;
		stageNext.sum = inStage.effSub ? sumSub : sumAdd;
		stageNext.sign = inStage.sign;
		stageNext.special = inStage.special;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			vld <= 1'b0;
		else
			vld <= inVld;
	end

	always_ff @(posedge aclk) begin
		stage <= stageNext;
	end

endmodule

`default_nettype wire

//--- source/fpNormalizeStage.sv
`timescale 1ns/10ps
`default_nettype none

module fpNormalizeStage (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input fpAddPkg::sumT inStage,
	output logic vld,
	output fpAddPkg::normT stage
);

	logic carry;
	logic [fpAddPkg::extW-1:0] body;           // Sum below the carry bit
	logic [3:0] lz;                             // Leading zeros in body
	logic [fpAddPkg::extW-1:0] shifted;
	logic [fpAddPkg::expW:0] expWide;
	fpAddPkg::normT stageNext;

	assign carry = inStage.sum[fpAddPkg::extW];
	assign body = inStage.sum[fpAddPkg::extW-1:0];
	assign expWide = {1'b0, inStage.exp};

	// Priority search, highest set bit wins
	always_comb begin
		lz = 4'(fpAddPkg::extW - 1);
		for (int i = 0; i < fpAddPkg::extW; i++) begin
			if (body[i])
				lz = 4'(fpAddPkg::extW - 1 - i);
		end
	end

	assign shifted = body << lz;                 // Sticky moves up with the rest

	always_comb begin
		stageNext.sign = inStage.sign;
		stageNext.special = inStage.special;
		stageNext.zero = (inStage.sum == '0);
		if (carry) begin
			// One right, old round and sticky merge
			stageNext.sig = {inStage.sum[fpAddPkg::extW:2], inStage.sum[1] | inStage.sum[0]};
			stageNext.exp = expWide + 1'b1;
			stageNext.uflow = 1'b0;
		end else begin
			stageNext.sig = shifted;
			stageNext.exp = expWide - lz;         // Wraps on underflow, masked below
			// Exponent would hit zero or go negative
			stageNext.uflow = (inStage.sum != '0) && (expWide <= lz);
		end
	end

	always_ff @(posedge aclk) begin
		if (rst)
			vld <= 1'b0;
		else
			vld <= inVld;
	end

	always_ff @(posedge aclk) begin
		stage <= stageNext;
	end

endmodule

`default_nettype wire

//--- source/fpRoundStage.sv
`timescale 1ns/10ps
`default_nettype none

module fpRoundStage (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input fpAddPkg::normT inStage,
	output logic outVld,
	output logic [fpAddPkg::dataW-1:0] result,
	output fpAddPkg::fpFlagsT flags
);

	logic guard, rnd, sticky;
	logic roundUp;
	logic lostBits;                             // Any grs bit set
	logic [fpAddPkg::sigW:0] rounded;          // Extra MSB for rounding carry
	logic [fpAddPkg::expW:0] expR;
	logic [fpAddPkg::dataW-1:0] infWord;
	logic [fpAddPkg::dataW-1:0] resultNext;
	fpAddPkg::fpFlagsT flagsNext;

	assign guard = inStage.sig[2];
	assign rnd = inStage.sig[1];
	assign sticky = inStage.sig[0];
	assign lostBits = |inStage.sig[fpAddPkg::grsW-1:0];

	// Nearest even, ties go up only on odd LSB
	assign roundUp = guard & (rnd | sticky | inStage.sig[fpAddPkg::grsW]);
	assign rounded = {1'b0, inStage.sig[fpAddPkg::extW-1:fpAddPkg::grsW]} + roundUp;
	assign expR = inStage.exp + rounded[fpAddPkg::sigW]; // 1.111.. rolls to 10.000..

	assign infWord = {inStage.sign, {fpAddPkg::expW{1'b1}}, {fpAddPkg::manW{1'b0}}};

	always_comb begin
		flagsNext = '0;
		resultNext = {inStage.sign, expR[fpAddPkg::expW-1:0], rounded[fpAddPkg::manW-1:0]};
		if (inStage.special == fpAddPkg::spNan || inStage.special == fpAddPkg::spInfMinusInf) begin
			resultNext = fpAddPkg::qNan;
			flagsNext.invalid = 1'b1;
		end else if (inStage.special == fpAddPkg::spInf) begin
			resultNext = infWord;                // Exact infinity, no inexact
			flagsNext.overflow = 1'b1;
		end else if (inStage.zero) begin
			resultNext = '0;                     // Exact cancellation gives +0
		end else if (inStage.uflow) begin
			resultNext = {inStage.sign, {(fpAddPkg::dataW-1){1'b0}}}; // Flush
			flagsNext.underflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else if (expR >= fpAddPkg::expMax) begin
			resultNext = infWord;
			flagsNext.overflow = 1'b1;
			flagsNext.inexact = 1'b1;
		end else begin
			flagsNext.inexact = lostBits;
		end
	end

	always_ff @(posedge aclk) begin
		if (rst)
			outVld <= 1'b0;
		else
			outVld <= inVld;
	end

	always_ff @(posedge aclk) begin
		result <= resultNext;
		flags <= flagsNext;
	end

endmodule

`default_nettype wire

//--- source/fpUnpackStage.sv
`timescale 1ns/10ps
`default_nettype none

module fpUnpackStage (
	input logic aclk,
	input logic rst,
	input logic inVld,
	input logic [fpAddPkg::dataW-1:0] opA,
	input logic [fpAddPkg::dataW-1:0] opB,
	input fpAddPkg::addSubOpE op,
	output logic vld,
	output fpAddPkg::unpackT stage
);

	logic [fpAddPkg::expW-1:0] expA, expB;
	logic [fpAddPkg::manW-1:0] fracA, fracB;
	logic signA, signB;
	logic zeroA, zeroB;
	logic nanA, nanB, infA, infB;
	logic [fpAddPkg::dataW-2:0] magA, magB;    // Magnitude without sign
	logic [fpAddPkg::sigW-1:0] sigA, sigB;
	logic aLarger;
	fpAddPkg::unpackT stageNext;

	assign expA = opA[fpAddPkg::dataW-2:fpAddPkg::manW];
	assign expB = opB[fpAddPkg::dataW-2:fpAddPkg::manW];
	assign fracA = opA[fpAddPkg::manW-1:0];
	assign fracB = opB[fpAddPkg::manW-1:0];
	assign signA = opA[fpAddPkg::dataW-1];
	assign signB = opB[fpAddPkg::dataW-1] ^ (op == fpAddPkg::opSub); // Sub flips B

	// No subnormals, exponent zero means zero
	assign zeroA = (expA == '0);
	assign zeroB = (expB == '0);
	assign nanA = (expA == fpAddPkg::expMax) && (fracA != '0);
	assign nanB = (expB == fpAddPkg::expMax) && (fracB != '0);
	assign infA = (expA == fpAddPkg::expMax) && (fracA == '0);
	assign infB = (expB == fpAddPkg::expMax) && (fracB == '0);

	assign sigA = zeroA ? '0 : {1'b1, fracA};     // Hidden one restored
	assign sigB = zeroB ? '0 : {1'b1, fracB};
	assign magA = zeroA ? '0 : opA[fpAddPkg::dataW-2:0];
	assign magB = zeroB ? '0 : opB[fpAddPkg::dataW-2:0];
	assign aLarger = (magA >= magB);              // Ties go to A

	always_comb begin
		stageNext.exp = aLarger ? expA : expB;
		stageNext.sigL = aLarger ? sigA : sigB;
		stageNext.sigS = aLarger ? sigB : sigA;
		stageNext.shift = aLarger ? expA - expB : expB - expA; // Never negative
		stageNext.sign = aLarger ? signA : signB;    // Larger operand sets the sign
		stageNext.effSub = signA ^ signB;
		if (nanA || nanB)
			stageNext.special = fpAddPkg::spNan;
		else if (infA && infB && (signA ^ signB))
			stageNext.special = fpAddPkg::spInfMinusInf;
		else if (infA || infB)
			stageNext.special = fpAddPkg::spInf;
		else
			stageNext.special = fpAddPkg::spNone;
	end

	always_ff @(posedge aclk) begin
		if (rst)
			vld <= 1'b0;
		else
			vld <= inVld;
	end

	always_ff @(posedge aclk) begin
		stage <= stageNext;
	end

endmodule

`default_nettype wire
